/* verilog/bus_ctrl_defs.svh */
// --------------------
// Host control register map: bus widths, addresses,
// field widths, reset values and compatibility number
// --------------------
`ifndef BUS_CTRL_DEFS_SVH
`define BUS_CTRL_DEFS_SVH

// Bus address widths
`define SR_AWIDTH         8
`define RB_AWIDTH         8

// --------------------
// Settings bus addresses
`define SR_LEDS           8'd0
`define SR_SW_RST         8'd1
`define SR_CLOCK_CTRL     8'd2
`define SR_SFPP_CTRL0     8'd8
`define SR_SFPP_CTRL1     8'd9
`define SR_FIFOFLAGS      8'd10

// --------------------
// Readback bus addresses
`define RB_COUNTER        8'd0
`define RB_CLK_STATUS     8'd3
`define RB_COMPAT_NUM     8'd6
`define RB_SFPP_STATUS0   8'd8
`define RB_SFPP_STATUS1   8'd9
`define RB_FIFOFLAGS      8'd10

// --------------------
// Field widths
`define LEDS_W            8
`define SW_RST_W          4
`define CLOCK_CTRL_W      7
`define CLOCK_STATUS_W    5
`define FIFO_FLAGS_W      4

// GPSDO enabled out of reset, bit 6 only
`define CLOCK_CTRL_RESET  7'b100_0000

// Compatibility word halves, major in the upper half
`define COMPAT_MAJOR      16'h0005
`define COMPAT_MINOR      16'h0000

`endif

/* verilog/bus_ctrl_pkg.sv */
// --------------------
// Host control types: settings and readback buses,
// SFP+ pin and status words, settings data decode
// --------------------
`include "bus_ctrl_defs.svh"

package bus_ctrl_pkg;

   // --------------------
   // Settings data word, field view
   // Upper bits unused by any register
   typedef struct packed {
      logic [24:0] pad;
      // Clock control bit 6
      logic        gpsdo_en;
      // Remaining clock control bits
      logic [3:0]  misc;
      // Rate selects, also clock control bits 1 and 0
      logic        rs1;
      logic        rs0;
   } set_fields_t;

   // Same 32 bits, decoded per address
   typedef union packed {
      logic [31:0] raw;
      set_fields_t fld;
   } set_word_u;

   // Settings bus, single-cycle write strobe
   typedef struct packed {
      logic                  stb;
      logic [`SR_AWIDTH-1:0] addr;
      set_word_u             data;
   } set_bus_t;

   // Readback request, data returns in the same cycle
   typedef struct packed {
      logic                  rd_stb;
      logic [`RB_AWIDTH-1:0] addr;
   } rb_req_t;

   // SFP+ module status pins, MSB first as read back
   typedef struct packed {
      logic mod_abs;
      logic tx_fault;
      logic rx_los;
   } sfpp_pins_t;

   // Change flags above the synchronized levels
   typedef struct packed {
      sfpp_pins_t chgd;
      sfpp_pins_t level;
   } sfpp_status_t;

endpackage

/* verilog/setting_regs.sv */
// --------------------
// Setting registers: decodes settings-bus writes into
// LED, reset, clock and rate-select registers, plus sticky FIFO errors
// --------------------
`include "bus_ctrl_defs.svh"

module setting_regs (
   input  logic                         clk,
   input  logic                         reset,
   input  bus_ctrl_pkg::set_bus_t       i_set,
   input  logic [`FIFO_FLAGS_W-1:0]     i_fifo_flags,
   output logic [`LEDS_W-1:0]           o_leds,
   output logic [`SW_RST_W-1:0]         o_sw_rst,
   output logic [`CLOCK_CTRL_W-1:0]     o_clock_control,
   output logic [1:0]                   o_sfpp0_rs_drive,
   output logic [1:0]                   o_sfpp1_rs_drive,
   output logic [`FIFO_FLAGS_W-1:0]     o_fifo_err
);
   import bus_ctrl_pkg::*;

   set_word_u word;
   logic      fifo_clr;

   // Data word seen through both views
   assign word = i_set.data;

   // --------------------
   // Setting registers
   // --------------------
   // One register per address, loaded on the strobe edge
   // SW_RST bits: 0 PHY, 1 radio clock domain, 2 radio PLL, 3 spare
   // Rate-select drives: high means pull the pin low
   always_ff @(posedge clk) begin
      if (reset) begin
         o_leds           <= '0;
         o_sw_rst         <= '0;
         o_clock_control  <= `CLOCK_CTRL_RESET;
         o_sfpp0_rs_drive <= '0;
         o_sfpp1_rs_drive <= '0;
      end else if (i_set.stb) begin
         case (i_set.addr)
            `SR_LEDS: begin
               o_leds <= word.raw[`LEDS_W-1:0];
            end
            `SR_SW_RST: begin
               o_sw_rst <= word.raw[`SW_RST_W-1:0];
            end
            `SR_CLOCK_CTRL: begin
               // GPSDO enable on top, then the lower six bits
               o_clock_control <= {word.fld.gpsdo_en, word.fld.misc,
                                   word.fld.rs1, word.fld.rs0};
            end
            `SR_SFPP_CTRL0: begin
               o_sfpp0_rs_drive <= {word.fld.rs1, word.fld.rs0};
            end
            `SR_SFPP_CTRL1: begin
               o_sfpp1_rs_drive <= {word.fld.rs1, word.fld.rs0};
            end
            // Unused addresses leave every register alone
            default: begin
            end
         endcase
      end
   end

   // --------------------
   // Sticky FIFO errors
   // --------------------
   // Any write to the flag address clears, data ignored
   assign fifo_clr = i_set.stb && (i_set.addr == `SR_FIFOFLAGS);

   // Flags are active low, collect every low cycle
   always_ff @(posedge clk) begin
      if (reset) begin
         o_fifo_err <= '0;
      end else if (fifo_clr) begin
         o_fifo_err <= '0;
      end else begin
         o_fifo_err <= o_fifo_err | ~i_fifo_flags;
      end
   end

endmodule

/* verilog/sfpp_status.sv */
// --------------------
// SFP+ status: two-stage pin synchronizer and
// per-pin change latch, cleared by a readback pulse
// --------------------
module sfpp_status (
   input  logic                       clk,
   input  logic                       reset,
   input  bus_ctrl_pkg::sfpp_pins_t   i_pins,
   input  logic                       i_clear,
   output bus_ctrl_pkg::sfpp_status_t o_status
);
   import bus_ctrl_pkg::*;

   sfpp_pins_t stage1;
   sfpp_pins_t stage2;
   sfpp_pins_t chgd;

   // Pins are asynchronous to clk
   always_ff @(posedge clk) begin
      if (reset) begin
         stage1 <= '0;
         stage2 <= '0;
      end else begin
         stage1 <= i_pins;
         stage2 <= stage1;
      end
   end

   // Stages differ while a new level moves through
   // Clear wins over a change on the same edge
   always_ff @(posedge clk) begin
      if (reset) begin
         chgd <= '0;
      end else if (i_clear) begin
         chgd <= '0;
      end else begin
         chgd <= chgd | (stage1 ^ stage2);
      end
   end

   // Second stage is the reported level
   assign o_status.chgd  = chgd;
   assign o_status.level = stage2;

endmodule

/* verilog/readback_mux.sv */
// --------------------
// Readback: cycle counter, combinational status word
// select and SFP+ clear-on-read pulses
// --------------------
`include "bus_ctrl_defs.svh"

module readback_mux (
   input  logic                         clk,
   input  logic                         reset,
   input  bus_ctrl_pkg::rb_req_t        i_rb,
   input  logic [`CLOCK_STATUS_W-1:0]   i_clock_status,
   input  bus_ctrl_pkg::sfpp_status_t   i_sfpp0,
   input  bus_ctrl_pkg::sfpp_status_t   i_sfpp1,
   input  logic [`FIFO_FLAGS_W-1:0]     i_fifo_err,
   output logic [31:0]                  o_rb_data,
   output logic [1:0]                   o_sfpp_clr
);

   logic [31:0] counter;

   // --------------------
   // Cycle counter
   // --------------------
   // Free-running, wraps at 32 bits
   always_ff @(posedge clk) begin
      if (reset) begin
         counter <= '0;
      end else begin
         counter <= counter + 32'd1;
      end
   end

   // --------------------
   // Word select
   // --------------------
   // Zero latency from the address
   // Narrow fields zero-extended
   always_comb begin
      case (i_rb.addr)
         `RB_COUNTER: begin
            o_rb_data = counter;
         end
         `RB_CLK_STATUS: begin
            o_rb_data = {{(32-`CLOCK_STATUS_W){1'b0}}, i_clock_status};
         end
         `RB_COMPAT_NUM: begin
            o_rb_data = {`COMPAT_MAJOR, `COMPAT_MINOR};
         end
         // Change flags in bits 5:3, levels in 2:0
         `RB_SFPP_STATUS0: begin
            o_rb_data = {26'b0, i_sfpp0};
         end
         `RB_SFPP_STATUS1: begin
            o_rb_data = {26'b0, i_sfpp1};
         end
         `RB_FIFOFLAGS: begin
            o_rb_data = {{(32-`FIFO_FLAGS_W){1'b0}}, i_fifo_err};
         end
         // Unmapped addresses
         default: begin
            o_rb_data = 32'd0;
         end
      endcase
   end

   // Read of a status word clears its change flags
   // Only decode of these addresses for the clear
   assign o_sfpp_clr[0] = i_rb.rd_stb && (i_rb.addr == `RB_SFPP_STATUS0);
   assign o_sfpp_clr[1] = i_rb.rd_stb && (i_rb.addr == `RB_SFPP_STATUS1);

endmodule

/* verilog/bus_ctrl_top.sv */
// --------------------
// Host control and status block, top level
// --------------------
`include "bus_ctrl_defs.svh"

module bus_ctrl_top (
   input  logic                         clk,
   input  logic                         reset,
   input  bus_ctrl_pkg::set_bus_t       i_set,
   input  bus_ctrl_pkg::rb_req_t        i_rb,
   input  logic [`CLOCK_STATUS_W-1:0]   i_clock_status,
   input  logic [`FIFO_FLAGS_W-1:0]     i_fifo_flags,
   input  bus_ctrl_pkg::sfpp_pins_t     i_sfpp0_pins,
   input  bus_ctrl_pkg::sfpp_pins_t     i_sfpp1_pins,
   output logic [31:0]                  o_rb_data,
   output logic [`LEDS_W-1:0]           o_leds,
   output logic [`SW_RST_W-1:0]         o_sw_rst,
   output logic [`CLOCK_CTRL_W-1:0]     o_clock_control,
   output logic [1:0]                   o_sfpp0_rs_drive,
   output logic [1:0]                   o_sfpp1_rs_drive
);
   import bus_ctrl_pkg::*;

   logic [`FIFO_FLAGS_W-1:0] fifo_err;
   logic [1:0]               sfpp_clr;
   sfpp_status_t             sfpp0_status;
   sfpp_status_t             sfpp1_status;

   // --------------------
   // Settings side
   setting_regs settings (
      .clk              (clk),
      .reset            (reset),
      .i_set            (i_set),
      .i_fifo_flags     (i_fifo_flags),
      .o_leds           (o_leds),
      .o_sw_rst         (o_sw_rst),
      .o_clock_control  (o_clock_control),
      .o_sfpp0_rs_drive (o_sfpp0_rs_drive),
      .o_sfpp1_rs_drive (o_sfpp1_rs_drive),
      .o_fifo_err       (fifo_err)
   );

   // --------------------
   // SFP+ pin monitors, one per cage
   sfpp_status port0 (
      .clk      (clk),
      .reset    (reset),
      .i_pins   (i_sfpp0_pins),
      .i_clear  (sfpp_clr[0]),
      .o_status (sfpp0_status)
   );

   sfpp_status port1 (
      .clk      (clk),
      .reset    (reset),
      .i_pins   (i_sfpp1_pins),
      .i_clear  (sfpp_clr[1]),
      .o_status (sfpp1_status)
   );

   // --------------------
   // Readback side
   readback_mux readback (
      .clk            (clk),
      .reset          (reset),
      .i_rb           (i_rb),
      .i_clock_status (i_clock_status),
      .i_sfpp0        (sfpp0_status),
      .i_sfpp1        (sfpp1_status),
      .i_fifo_err     (fifo_err),
      .o_rb_data      (o_rb_data),
      .o_sfpp_clr     (sfpp_clr)
   );

endmodule

/* testbench/bus_ctrl_sva.sv */
// --------------------
// Assertions on the host control top level
// --------------------
`include "bus_ctrl_defs.svh"

module bus_ctrl_sva (
   input logic                       clk,
   input logic                       reset,
   input logic [1:0]                 sfpp_clr,
   input bus_ctrl_pkg::sfpp_status_t sfpp0_status,
   input bus_ctrl_pkg::sfpp_status_t sfpp1_status,
   input logic [6:0]                 clock_control,
   input bus_ctrl_pkg::rb_req_t      rb_req,
   input logic [31:0]                rb_data
);
   timeunit 1ns;
   timeprecision 100ps;

   // Clear pulse empties the change flags on the next edge
   clr0_zeroes_chgd: assert property (@(posedge clk) disable iff (reset)
      sfpp_clr[0] |=> (sfpp0_status.chgd == 3'b000))
      else $error("port0 change flags still set after clear pulse");

   clr1_zeroes_chgd: assert property (@(posedge clk) disable iff (reset)
      sfpp_clr[1] |=> (sfpp1_status.chgd == 3'b000))
      else $error("port1 change flags still set after clear pulse");

   // GPSDO enable set, nothing else
   clock_ctrl_reset: assert property (@(posedge clk)
      reset |=> (clock_control == `CLOCK_CTRL_RESET))
      else $error("clock control not at reset value after reset");

   // Counter word steps by one while the address holds
   counter_steps: assert property (@(posedge clk) disable iff (reset)
      (rb_req.addr == `RB_COUNTER && $past(rb_req.addr) == `RB_COUNTER && !$past(reset))
      |-> (rb_data == $past(rb_data) + 32'd1))
      else $error("counter readback did not advance by one");

endmodule

bind bus_ctrl_top bus_ctrl_sva sva (
   .clk           (clk),
   .reset         (reset),
   .sfpp_clr      (sfpp_clr),
   .sfpp0_status  (sfpp0_status),
   .sfpp1_status  (sfpp1_status),
   .clock_control (o_clock_control),
   .rb_req        (i_rb),
   .rb_data       (o_rb_data)
);

/* testbench/bus_ctrl_tb.sv */
// --------------------
// Testbench for the host control block with directed
// register, SFP+ status, FIFO-error and counter tests
// --------------------
`include "bus_ctrl_defs.svh"

module bus_ctrl_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import bus_ctrl_pkg::*;

   localparam int CLK_PERIOD     = 8;
   // Far above the hundred or so cycles the tests run
   localparam int TIMEOUT_CYCLES = 2500;

   logic        clk;
   logic        reset;
   set_bus_t    set_bus;
   rb_req_t     rb_req;
   logic [4:0]  clock_status;
   logic [3:0]  fifo_flags;
   sfpp_pins_t  sfpp0_pins;
   sfpp_pins_t  sfpp1_pins;
   logic [31:0] rb_data;
   logic [7:0]  leds;
   logic [3:0]  sw_rst;
   logic [6:0]  clock_control;
   logic [1:0]  sfpp0_rs;
   logic [1:0]  sfpp1_rs;
   integer      seed;
   int          checks;
   int          errors;

   bus_ctrl_top dut (
      .clk              (clk),
      .reset            (reset),
      .i_set            (set_bus),
      .i_rb             (rb_req),
      .i_clock_status   (clock_status),
      .i_fifo_flags     (fifo_flags),
      .i_sfpp0_pins     (sfpp0_pins),
      .i_sfpp1_pins     (sfpp1_pins),
      .o_rb_data        (rb_data),
      .o_leds           (leds),
      .o_sw_rst         (sw_rst),
      .o_clock_control  (clock_control),
      .o_sfpp0_rs_drive (sfpp0_rs),
      .o_sfpp1_rs_drive (sfpp1_rs)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // --------------------
   // Helpers
   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("MISMATCH %s expected 0x%08h actual 0x%08h", name, expected, actual);
      end
   endtask

   // Inputs change 1 ns after the rising edge
   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) next_cycle();
   endtask

   // Strobe held for exactly one edge
   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      set_bus.stb      = 1'b1;
      set_bus.addr     = addr;
      set_bus.data.raw = data;
      next_cycle();
      set_bus.stb = 1'b0;
   endtask

   // Combinational data sampled mid-cycle
   // Each read uses up one cycle
   task automatic read_word(input logic [7:0] addr, input logic strobe,
                            output logic [31:0] data);
      rb_req.rd_stb = strobe;
      rb_req.addr   = addr;
      #2;
      data = rb_data;
      next_cycle();
      rb_req.rd_stb = 1'b0;
   endtask

   task automatic check_settings(input string name, input logic [31:0] exp_leds,
                                 input logic [31:0] exp_sw_rst,
                                 input logic [31:0] exp_clk_ctrl,
                                 input logic [31:0] exp_rs0, input logic [31:0] exp_rs1);
      check_value({name, " leds"}, exp_leds, 32'(leds));
      check_value({name, " sw_rst"}, exp_sw_rst, 32'(sw_rst));
      check_value({name, " clock_ctrl"}, exp_clk_ctrl, 32'(clock_control));
      check_value({name, " sfpp0 rs"}, exp_rs0, 32'(sfpp0_rs));
      check_value({name, " sfpp1 rs"}, exp_rs1, 32'(sfpp1_rs));
   endtask

   // --------------------
   // Directed tests
   task automatic test_reset_values();
      logic [31:0] word;
      // GPSDO enable is the only bit set out of reset
      check_settings("reset", 32'h0, 32'h0, 32'h40, 32'h0, 32'h0);
      read_word(`RB_COMPAT_NUM, 1'b0, word);
      check_value("reset compat", 32'h0005_0000, word);
      read_word(8'd5, 1'b0, word);
      check_value("reset unmapped", 32'h0, word);
   endtask

   task automatic test_setting_writes();
      logic [31:0] w_leds;
      logic [31:0] w_sw;
      logic [31:0] w_clk;
      logic [31:0] w_rs0;
      logic [31:0] w_rs1;
      logic [31:0] w_spare;
      w_leds  = $random(seed);
      w_sw    = $random(seed);
      w_clk   = $random(seed);
      w_rs0   = $random(seed);
      w_rs1   = $random(seed);
      w_spare = $random(seed);
      // Each register keeps only its low field bits
      write_setting(`SR_LEDS, w_leds);
      check_value("write leds", w_leds & 32'hFF, 32'(leds));
      write_setting(`SR_SW_RST, w_sw);
      check_value("write sw_rst", w_sw & 32'hF, 32'(sw_rst));
      write_setting(`SR_CLOCK_CTRL, w_clk);
      check_value("write clock_ctrl", w_clk & 32'h7F, 32'(clock_control));
      write_setting(`SR_SFPP_CTRL0, w_rs0);
      check_value("write sfpp0 rs", w_rs0 & 32'h3, 32'(sfpp0_rs));
      write_setting(`SR_SFPP_CTRL1, w_rs1);
      check_value("write sfpp1 rs", w_rs1 & 32'h3, 32'(sfpp1_rs));
      // Nothing moves on an unused address
      write_setting(8'd5, w_spare);
      check_settings("unused write", w_leds & 32'hFF, w_sw & 32'hF, w_clk & 32'h7F,
                     w_rs0 & 32'h3, w_rs1 & 32'h3);
   endtask

   task automatic test_sfpp_status();
      logic [31:0] word;
      // Status word has chgd in 5:3 and level in 2:0
      // mod_abs is the top bit of each half
      sfpp0_pins.tx_fault = 1'b1;
      sfpp1_pins.rx_los   = 1'b1;
      wait_cycles(4);
      read_word(`RB_SFPP_STATUS1, 1'b0, word);
      check_value("sfpp1 changed", 32'h09, word);
      read_word(`RB_SFPP_STATUS0, 1'b1, word);
      check_value("sfpp0 changed", 32'h12, word);
      // Strobed read drops chgd while level stays
      read_word(`RB_SFPP_STATUS0, 1'b0, word);
      check_value("sfpp0 cleared", 32'h02, word);
      read_word(`RB_SFPP_STATUS1, 1'b1, word);
      check_value("sfpp1 kept", 32'h09, word);
      // Port 1 clears on its own strobe too
      read_word(`RB_SFPP_STATUS1, 1'b0, word);
      check_value("sfpp1 cleared", 32'h01, word);
   endtask

   task automatic test_fifo_errors();
      logic [31:0] word;
      logic [31:0] clr_data;
      // Active-low flags
      // Bit 2 pulled low for one cycle
      fifo_flags = 4'b1011;
      next_cycle();
      fifo_flags = 4'hF;
      read_word(`RB_FIFOFLAGS, 1'b0, word);
      check_value("fifo error set", 32'h4, word);
      wait_cycles(5);
      read_word(`RB_FIFOFLAGS, 1'b0, word);
      check_value("fifo error sticky", 32'h4, word);
      clr_data = $random(seed);
      write_setting(`SR_FIFOFLAGS, clr_data);
      read_word(`RB_FIFOFLAGS, 1'b0, word);
      check_value("fifo error cleared", 32'h0, word);
      // Clock status passes straight through
      word = $random(seed);
      clock_status = word[4:0];
      read_word(`RB_CLK_STATUS, 1'b0, clr_data);
      check_value("clock status", word & 32'h1F, clr_data);
   endtask

   task automatic test_counter();
      logic [31:0] first;
      logic [31:0] second;
      read_word(`RB_COUNTER, 1'b0, first);
      // First read used one of the 37 cycles
      wait_cycles(36);
      read_word(`RB_COUNTER, 1'b0, second);
      check_value("counter step", 32'd37, second - first);
   endtask

   // --------------------
   // Main sequence
   initial begin
      seed         = 74076;
      checks       = 0;
      errors       = 0;
      clk          = 1'b0;
      reset        = 1'b1;
      set_bus      = '0;
      rb_req       = '0;
      clock_status = '0;
      fifo_flags   = 4'hF;
      sfpp0_pins   = '0;
      sfpp1_pins   = '0;
      repeat (8) @(posedge clk);
      #1;
      reset = 1'b0;
      test_reset_values();
      test_setting_writes();
      test_sfpp_status();
      test_fifo_errors();
      test_counter();
      $display("Summary: %0d checks, %0d mismatches", checks, errors);
      if (errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(TIMEOUT_CYCLES * CLK_PERIOD);
      $display("Watchdog: tests still running after %0d ns, run stopped",
               TIMEOUT_CYCLES * CLK_PERIOD);
      $display("Test FAILED");
      $finish;
   end

endmodule

/* project.f */
+incdir+verilog
verilog/bus_ctrl_pkg.sv
verilog/setting_regs.sv
verilog/sfpp_status.sv
verilog/readback_mux.sv
verilog/bus_ctrl_top.sv
testbench/bus_ctrl_sva.sv
testbench/bus_ctrl_tb.sv

/* Makefile */
# Verilator lint and simulation of the host control block
TOP = bus_ctrl_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/100ps -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps -f project.f \
	   --top-module $(TOP) --Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "Test FAILED" sim.log || ! grep -q "Test OK" sim.log; then \
	   echo "Simulation failed, see sim.log"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
